/* hdl/deparse_pkg.sv */
package deparse_pkg;

	localparam int DATA_W    = 256;
	localparam int KEEP_W    = DATA_W / 8;
	localparam int NUM_ACT   = 4;
	localparam int NUM_CONT  = 4;
	localparam int TBL_DEPTH = 16;
	localparam int TBL_AW    = 4;
	localparam int VLAN_W    = 12;
	localparam int VLAN_LSB  = 4; // first vlan id bit used as table address

	typedef struct packed {
		logic [DATA_W-1:0] data;
		logic [KEEP_W-1:0] keep;
		logic              last;
	} seg_t;

	typedef struct packed {
		logic [NUM_CONT-1:0][15:0] c2;
		logic [NUM_CONT-1:0][31:0] c4;
		logic [NUM_CONT-1:0][47:0] c6;
		logic                      discard;
	} phv_t;

	// ctype 1, 2, 3 selects a 2, 4 or 6 byte container
	typedef struct packed {
		logic       en;
		logic [1:0] ctype;
		logic [1:0] cidx;
		logic [4:0] off;   // byte offset in header beat
		logic [5:0] spare;
	} act_t;

	typedef act_t [0:NUM_ACT-1] entry_t; // action 0 in the top bits

	typedef struct packed {
		logic [1:0]  ctype;
		logic [47:0] val;   // msb aligned
	} fval_t;

endpackage

/* hdl/ctrl_pkg.sv */
package ctrl_pkg;

	localparam int CTRL_W = 64;

	localparam logic [2:0]  MOD_ID    = 3'd5;
	localparam logic [15:0] CTRL_FLAG = 16'hf2f1;

	// field positions in the header beat
	localparam int MOD_LSB  = 0;
	localparam int FLAG_LSB = 16;
	localparam int IDX_LSB  = 32;

	typedef struct packed {
		logic [CTRL_W-1:0] data;
		logic              last;
	} ctrl_beat_t;

endpackage

/* hdl/action_table.sv */
module action_table (
	input  logic                             clk,
	input  logic                             aresetn,
	input  ctrl_pkg::ctrl_beat_t             ctrl,
	input  logic                             ctrl_valid,
	input  logic [deparse_pkg::TBL_AW-1:0]   rd_addr,
	output deparse_pkg::entry_t              entry
);

	typedef enum logic [1:0] {C_IDLE, C_FIRST, C_NEXT} c_state_t;

	c_state_t                         c_state;
	logic [deparse_pkg::TBL_AW-1:0]   c_index;
	logic                             c_wr_en;
	logic [ctrl_pkg::CTRL_W-1:0]      swapped;
	logic                             hdr_match;
	deparse_pkg::entry_t              wr_entry;
	deparse_pkg::entry_t              mem [deparse_pkg::TBL_DEPTH];

	// byte 0 of the beat lands in the top byte
	always_comb begin
		for (int b = 0; b < ctrl_pkg::CTRL_W / 8; b++) begin
			swapped[ctrl_pkg::CTRL_W - 8 - 8 * b +: 8] = ctrl.data[8 * b +: 8];
		end
	end

	assign hdr_match = ctrl_valid
		&& ctrl.data[ctrl_pkg::MOD_LSB +: 3] == ctrl_pkg::MOD_ID
		&& ctrl.data[ctrl_pkg::FLAG_LSB +: 16] == ctrl_pkg::CTRL_FLAG;

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			c_state <= C_IDLE;
			c_index <= '0;
			c_wr_en <= 1'b0;
		end else begin
			c_wr_en <= 1'b0;
			case (c_state)
				C_IDLE: begin
					if (hdr_match) begin
						c_index <= ctrl.data[ctrl_pkg::IDX_LSB +: deparse_pkg::TBL_AW];
						c_state <= C_FIRST;
					end
				end
				C_FIRST, C_NEXT: begin
					if (ctrl_valid) begin
						c_wr_en <= 1'b1;
						if (c_state == C_NEXT)
							c_index <= c_index + 1'b1; // following entries go to index+1
						c_state <= ctrl.last ? C_IDLE : C_NEXT;
					end
				end
				default: c_state <= C_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (ctrl_valid)
			wr_entry <= deparse_pkg::entry_t'(swapped);
	end

	always_ff @(posedge clk) begin
		if (c_wr_en)
			mem[c_index] <= wr_entry;
		entry <= mem[rd_addr]; // registered read
	end

endmodule

/* hdl/field_extractor.sv */
module field_extractor (
	input  logic                                        clk,
	input  logic                                        aresetn,
	input  deparse_pkg::phv_t                           phv,
	input  deparse_pkg::entry_t                         entry,
	input  logic                                        load,
	output deparse_pkg::fval_t [deparse_pkg::NUM_ACT-1:0] fields
);

	deparse_pkg::fval_t [deparse_pkg::NUM_ACT-1:0] sel;

	always_comb begin
		for (int a = 0; a < deparse_pkg::NUM_ACT; a++) begin
			sel[a].ctype = entry[a].en ? entry[a].ctype : 2'd0;
			case (entry[a].ctype)
				2'd1:    sel[a].val = {phv.c2[entry[a].cidx], 32'h0};
				2'd2:    sel[a].val = {phv.c4[entry[a].cidx], 16'h0};
				2'd3:    sel[a].val = phv.c6[entry[a].cidx];
				default: sel[a].val = '0;
			endcase
		end
	end

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn)
			fields <= '0;
		else if (load)
			fields <= sel;
	end

endmodule

/* hdl/deparse_step_counter.sv */
module deparse_step_counter (
	input  logic                                      clk,
	input  logic                                      aresetn,
	input  logic                                      start,
	output logic [$clog2(deparse_pkg::NUM_ACT)-1:0]   step,
	output logic                                      active,
	output logic                                      last_step
);

	assign last_step = active && step == $clog2(deparse_pkg::NUM_ACT)'(deparse_pkg::NUM_ACT - 1);

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			step   <= '0;
			active <= 1'b0;
		end else if (start) begin
			step   <= '0;
			active <= 1'b1;
		end else if (active) begin
			step <= step + 1'b1;
			if (last_step)
				active <= 1'b0;
		end
	end

endmodule

/* hdl/header_patcher.sv */
module header_patcher (
	input  logic                                        clk,
	input  logic                                        aresetn,
	input  logic                                        load,
	input  deparse_pkg::seg_t                           hdr_in,
	input  deparse_pkg::entry_t                         entry,
	input  deparse_pkg::fval_t [deparse_pkg::NUM_ACT-1:0] fields,
	input  logic [$clog2(deparse_pkg::NUM_ACT)-1:0]     step,
	input  logic                                        active,
	output deparse_pkg::seg_t                           hdr
);

	deparse_pkg::seg_t patched;

	always_comb begin
		int nbytes;
		int pos;
		patched = hdr;
		nbytes  = 2 * int'(fields[step].ctype); // 0 when action disabled
		for (int k = 0; k < 6; k++) begin
			pos = int'(entry[step].off) + k;
			if (k < nbytes && pos < deparse_pkg::KEEP_W)
				patched.data[pos * 8 +: 8] = fields[step].val[47 - 8 * k -: 8];
		end
	end

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn)
			hdr <= '0;
		else if (load)
			hdr <= hdr_in;
		else if (active)
			hdr <= patched; // one action per cycle
	end

endmodule

/* hdl/deparse_fsm.sv */
module deparse_fsm (
	input  logic clk,
	input  logic aresetn,
	input  logic vlan_empty,
	input  logic phv_empty,
	input  logic hdr_empty,
	input  logic pay_empty,
	input  logic discard,
	input  logic hdr_last,
	input  logic pay_last,
	output logic phv_rd_en,
	output logic vlan_rd_en,
	output logic hdr_rd_en,
	output logic pay_rd_en,
	output logic load,
	output logic step_start,
	output logic push,
	output logic sel_pay,
	input  logic last_step,
	input  logic egress_free
);

	typedef enum logic [2:0] {
		IDLE, LOOKUP, WAIT, PATCH, SEND_HDR, SEND_PAY, DROP_PAY
	} state_t;

	state_t state, state_next;

	always_comb begin
		state_next = state;
		phv_rd_en  = 1'b0;
		vlan_rd_en = 1'b0;
		hdr_rd_en  = 1'b0;
		pay_rd_en  = 1'b0;
		load       = 1'b0;
		step_start = 1'b0;
		push       = 1'b0;
		sel_pay    = 1'b0;
		case (state)
			IDLE: if (!vlan_empty) state_next = LOOKUP;
			LOOKUP: state_next = WAIT; // table read in flight
			WAIT: begin
				if (!phv_empty && !hdr_empty) begin
					if (discard) begin
						phv_rd_en  = 1'b1;
						vlan_rd_en = 1'b1;
						hdr_rd_en  = 1'b1;
						state_next = hdr_last ? IDLE : DROP_PAY;
					end else begin
						load       = 1'b1;
						step_start = 1'b1;
						state_next = PATCH;
					end
				end
			end
			PATCH: if (last_step) state_next = SEND_HDR;
			SEND_HDR: begin
				if (egress_free) begin
					push       = 1'b1;
					phv_rd_en  = 1'b1;
					vlan_rd_en = 1'b1;
					hdr_rd_en  = 1'b1;
					state_next = hdr_last ? IDLE : SEND_PAY;
				end
			end
			SEND_PAY: begin
				sel_pay = 1'b1;
				if (!pay_empty && egress_free) begin
					push      = 1'b1;
					pay_rd_en = 1'b1;
					if (pay_last) state_next = IDLE;
				end
			end
			DROP_PAY: begin
				if (!pay_empty) begin
					pay_rd_en = 1'b1;
					if (pay_last) state_next = IDLE;
				end
			end
			default: state_next = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn)
			state <= IDLE;
		else
			state <= state_next;
	end

endmodule

/* hdl/egress_stage.sv */
module egress_stage (
	input  logic              clk,
	input  logic              aresetn,
	input  logic              push,
	input  logic              sel_pay,
	input  deparse_pkg::seg_t hdr,
	input  deparse_pkg::seg_t pay,
	output deparse_pkg::seg_t out,
	output logic              out_valid,
	input  logic              out_ready,
	output logic              free
);

	assign free = !out_valid || out_ready; // empty or draining now

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn)
			out_valid <= 1'b0;
		else if (push)
			out_valid <= 1'b1;
		else if (out_ready)
			out_valid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (push)
			out <= sel_pay ? pay : hdr;
	end

endmodule

/* hdl/deparser_top.sv */
module deparser_top (
	input  logic                             clk,
	input  logic                             aresetn,
	input  deparse_pkg::phv_t                phv,
	input  logic                             phv_empty,
	output logic                             phv_rd_en,
	input  logic [deparse_pkg::VLAN_W-1:0]   vlan,
	input  logic                             vlan_empty,
	output logic                             vlan_rd_en,
	input  deparse_pkg::seg_t                hdr,
	input  logic                             hdr_empty,
	output logic                             hdr_rd_en,
	input  deparse_pkg::seg_t                pay,
	input  logic                             pay_empty,
	output logic                             pay_rd_en,
	output deparse_pkg::seg_t                out,
	output logic                             out_valid,
	input  logic                             out_ready,
	input  ctrl_pkg::ctrl_beat_t             ctrl,
	input  logic                             ctrl_valid
);

	deparse_pkg::entry_t                           entry;
	deparse_pkg::fval_t [deparse_pkg::NUM_ACT-1:0] fields;
	deparse_pkg::seg_t                             patched_hdr;
	logic [$clog2(deparse_pkg::NUM_ACT)-1:0]       step;
	logic active, last_step, load, step_start, push, sel_pay, egress_free;

	action_table u_table (
		.clk, .aresetn, .ctrl, .ctrl_valid,
		.rd_addr (vlan[deparse_pkg::VLAN_LSB +: deparse_pkg::TBL_AW]), // vlan id bits 7:4
		.entry
	);

	field_extractor u_extract (.clk, .aresetn, .phv, .entry, .load, .fields);

	deparse_step_counter u_steps (
		.clk, .aresetn, .start (step_start), .step, .active, .last_step
	);

	header_patcher u_patch (
		.clk, .aresetn, .load, .hdr_in (hdr), .entry, .fields, .step, .active,
		.hdr (patched_hdr)
	);

	deparse_fsm u_fsm (
		.clk, .aresetn, .vlan_empty, .phv_empty, .hdr_empty, .pay_empty,
		.discard (phv.discard), .hdr_last (hdr.last), .pay_last (pay.last),
		.phv_rd_en, .vlan_rd_en, .hdr_rd_en, .pay_rd_en,
		.load, .step_start, .push, .sel_pay, .last_step, .egress_free
	);

	egress_stage u_egress (
		.clk, .aresetn, .push, .sel_pay, .hdr (patched_hdr), .pay,
		.out, .out_valid, .out_ready, .free (egress_free)
	);

endmodule

/* verification/tb_deparser.sv */
module tb_deparser;

	logic                 clk;
	logic                 aresetn;
	deparse_pkg::phv_t    phv;
	logic                 phv_empty, phv_rd_en;
	logic [11:0]          vlan;
	logic                 vlan_empty, vlan_rd_en;
	deparse_pkg::seg_t    hdr;
	logic                 hdr_empty, hdr_rd_en;
	deparse_pkg::seg_t    pay;
	logic                 pay_empty, pay_rd_en;
	deparse_pkg::seg_t    out;
	logic                 out_valid, out_ready;
	ctrl_pkg::ctrl_beat_t ctrl;
	logic                 ctrl_valid;

	deparse_pkg::phv_t    phv_q[$];
	logic [11:0]          vlan_q[$];
	deparse_pkg::seg_t    hdr_q[$];
	deparse_pkg::seg_t    pay_q[$];
	deparse_pkg::seg_t    exp_q[$];
	deparse_pkg::entry_t  ctrl_ents[$];
	deparse_pkg::entry_t  tbl [16]; // table model
	deparse_pkg::entry_t  e;
	deparse_pkg::seg_t    exp_beat;
	logic [31:0]          stim_lfsr  = 32'h8317;
	logic [31:0]          ready_lfsr = 32'h8317;
	logic                 rand_ready = 1'b0;
	logic                 pop_phv, pop_vlan, pop_hdr, pop_pay;
	int                   pkt_exp = 0;
	int                   pkt_seen = 0;
	int                   picks [5] = '{3, 8, 9, 10, 12};

	deparser_top UUT (.*);

	always #10 clk = ~clk;

	task automatic report_failure(string why);
		$display("%s", why);
		$display("test failed");
		$fatal(1);
	endtask

	task automatic check_seg(string name, deparse_pkg::seg_t got, deparse_pkg::seg_t exp);
		if (got !== exp)
			report_failure($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
	endtask

	task automatic check_count(string name, int got, int exp);
		if (got !== exp)
			report_failure($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
	endtask

	function automatic logic [31:0] lfsr_step(logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	function automatic logic [31:0] rand_bits(int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], stim_lfsr[0]};
			stim_lfsr = lfsr_step(stim_lfsr);
		end
		return v;
	endfunction

	function automatic deparse_pkg::act_t mk_act(logic en, int ctype, int cidx, int off);
		deparse_pkg::act_t a;
		a = '0;
		a.en    = en;
		a.ctype = 2'(ctype);
		a.cidx  = 2'(cidx);
		a.off   = 5'(off);
		return a;
	endfunction

	// byte k of a container, most significant first
	function automatic logic [7:0] cont_byte(deparse_pkg::phv_t p, logic [1:0] ctype,
			logic [1:0] cidx, int k);
		case (ctype)
			2'd1:    return p.c2[cidx][8 * (1 - k) +: 8];
			2'd2:    return p.c4[cidx][8 * (3 - k) +: 8];
			default: return p.c6[cidx][8 * (5 - k) +: 8];
		endcase
	endfunction

	function automatic deparse_pkg::seg_t patch_ref(deparse_pkg::entry_t ent,
			deparse_pkg::phv_t p, deparse_pkg::seg_t h);
		deparse_pkg::seg_t r;
		deparse_pkg::act_t a;
		int n;
		int pos;
		r = h;
		for (int i = 0; i < 4; i++) begin
			a = ent[i];
			n = a.en ? 2 * int'(a.ctype) : 0;
			for (int k = 0; k < n; k++) begin
				pos = int'(a.off) + k;
				if (pos < 32) r.data[8 * pos +: 8] = cont_byte(p, a.ctype, a.cidx, k); // later wins
			end
		end
		return r;
	endfunction

	function automatic deparse_pkg::seg_t rand_beat(logic last);
		deparse_pkg::seg_t s;
		for (int w = 0; w < 8; w++)
			s.data[32 * w +: 32] = rand_bits(32);
		s.keep = rand_bits(32);
		s.last = last;
		return s;
	endfunction

	function automatic logic [63:0] entry_beat(deparse_pkg::entry_t ent);
		logic [63:0] v;
		logic [63:0] d;
		v = ent;
		for (int b = 0; b < 8; b++)
			d[8 * b +: 8] = v[56 - 8 * b +: 8]; // beat byte 0 is entry top byte
		return d;
	endfunction

	task automatic send_ctrl_stream(logic [7:0] mod, logic [15:0] flag, logic [7:0] idx);
		@(posedge clk);
		#1;
		ctrl.data  = {24'h0, idx, flag, 8'h00, mod};
		ctrl.last  = 1'b0;
		ctrl_valid = 1'b1;
		foreach (ctrl_ents[i]) begin
			@(posedge clk);
			#1;
			ctrl.data = entry_beat(ctrl_ents[i]);
			ctrl.last = (i == ctrl_ents.size() - 1);
		end
		@(posedge clk);
		#1;
		ctrl_valid = 1'b0;
		ctrl       = '0;
		if (mod[2:0] == ctrl_pkg::MOD_ID && flag == ctrl_pkg::CTRL_FLAG) begin
			foreach (ctrl_ents[i])
				tbl[(int'(idx) + i) % 16] = ctrl_ents[i];
		end
		repeat (3) @(posedge clk); // write lands two cycles after the last beat
	endtask

	task automatic send_packet(int idx, int nbeats, logic drop);
		deparse_pkg::phv_t p;
		deparse_pkg::seg_t h;
		deparse_pkg::seg_t b;
		logic [11:0] v;
		v = 12'(rand_bits(12));
		v[deparse_pkg::VLAN_LSB +: 4] = 4'(idx);
		for (int i = 0; i < 4; i++) begin
			p.c2[i] = 16'(rand_bits(16));
			p.c4[i] = rand_bits(32);
			p.c6[i] = {16'(rand_bits(16)), rand_bits(32)};
		end
		p.discard = drop;
		h = rand_beat(nbeats == 1);
		vlan_q.push_back(v);
		phv_q.push_back(p);
		hdr_q.push_back(h);
		if (!drop) begin
			exp_q.push_back(patch_ref(tbl[idx], p, h));
			pkt_exp++;
		end
		for (int i = 1; i < nbeats; i++) begin
			b = rand_beat(i == nbeats - 1);
			pay_q.push_back(b);
			if (!drop) exp_q.push_back(b); // payload passes unchanged
		end
	endtask

	// done once every input FIFO is drained and the output register is empty
	task automatic wait_idle(int limit);
		int n;
		n = 0;
		while (phv_q.size() != 0 || vlan_q.size() != 0 || hdr_q.size() != 0
				|| pay_q.size() != 0 || out_valid) begin
			@(negedge clk);
			n++;
			if (n > limit) report_failure("timeout waiting for the packets to drain");
		end
	endtask

	// rd_en settles well before the next edge
	always @(negedge clk) begin
		pop_phv  = phv_rd_en;
		pop_vlan = vlan_rd_en;
		pop_hdr  = hdr_rd_en;
		pop_pay  = pay_rd_en;
	end

	always @(posedge clk) begin
		#1;
		if (pop_phv) begin
			if (phv_q.size() == 0) report_failure("phv FIFO read while empty");
			else void'(phv_q.pop_front());
		end
		if (pop_vlan) begin
			if (vlan_q.size() == 0) report_failure("vlan FIFO read while empty");
			else void'(vlan_q.pop_front());
		end
		if (pop_hdr) begin
			if (hdr_q.size() == 0) report_failure("hdr FIFO read while empty");
			else void'(hdr_q.pop_front());
		end
		if (pop_pay) begin
			if (pay_q.size() == 0) report_failure("pay FIFO read while empty");
			else void'(pay_q.pop_front());
		end
		phv_empty  = phv_q.size() == 0;
		vlan_empty = vlan_q.size() == 0;
		hdr_empty  = hdr_q.size() == 0;
		pay_empty  = pay_q.size() == 0;
		phv  = phv_empty ? '0 : phv_q[0];
		vlan = vlan_empty ? '0 : vlan_q[0];
		hdr  = hdr_empty ? '0 : hdr_q[0];
		pay  = pay_empty ? '0 : pay_q[0];
		out_ready = rand_ready ? ready_lfsr[0] : 1'b1;
		if (rand_ready) ready_lfsr = lfsr_step(ready_lfsr);
	end

	always @(negedge clk) begin
		if (aresetn && out_valid && out_ready) begin
			if (exp_q.size() == 0) begin
				report_failure("output beat seen while no beat was expected");
			end else begin
				exp_beat = exp_q.pop_front();
				check_seg("out", out, exp_beat);
				if (out.last) pkt_seen++;
			end
		end
	end

	initial begin
		clk        = 1'b0;
		aresetn    = 1'b0;
		phv        = '0;
		phv_empty  = 1'b1;
		vlan       = '0;
		vlan_empty = 1'b1;
		hdr        = '0;
		hdr_empty  = 1'b1;
		pay        = '0;
		pay_empty  = 1'b1;
		out_ready  = 1'b1;
		ctrl       = '0;
		ctrl_valid = 1'b0;
		repeat (5) @(posedge clk);
		#1 aresetn = 1'b1;

		// all sizes plus a disabled action
		e[0] = mk_act(1, 1, 2, 0);
		e[1] = mk_act(1, 2, 1, 4);
		e[2] = mk_act(0, 3, 0, 10);
		e[3] = mk_act(1, 3, 3, 12);
		ctrl_ents = '{e};
		send_ctrl_stream(8'h05, ctrl_pkg::CTRL_FLAG, 8'd3);
		send_packet(3, 1, 1'b0);
		wait_idle(200);
		send_packet(3, 4, 1'b0);
		wait_idle(200);

		send_packet(3, 1, 1'b1);
		send_packet(3, 3, 1'b1);
		send_packet(3, 2, 1'b0);
		wait_idle(300);

		// bad mod id, then bad flag
		e[0] = mk_act(1, 3, 1, 1);
		e[1] = mk_act(1, 1, 0, 30);
		ctrl_ents = '{e};
		send_ctrl_stream(8'h06, ctrl_pkg::CTRL_FLAG, 8'd3);
		send_ctrl_stream(8'h05, 16'hf2f0, 8'd3);
		send_packet(3, 1, 1'b0);
		wait_idle(200);

		ctrl_ents = {};
		for (int i = 0; i < 3; i++) begin
			for (int a = 0; a < 4; a++)
				e[a] = mk_act(rand_bits(1) | rand_bits(1), int'(rand_bits(2)), int'(rand_bits(2)),
					int'(rand_bits(5)));
			ctrl_ents.push_back(e);
		end
		send_ctrl_stream(8'h05, ctrl_pkg::CTRL_FLAG, 8'd8);
		for (int i = 8; i < 11; i++)
			send_packet(i, 2, 1'b0);
		wait_idle(400);

		// overlap and truncation past byte 31
		e[0] = mk_act(1, 3, 0, 20);
		e[1] = mk_act(1, 2, 1, 22);
		e[2] = mk_act(1, 3, 2, 29);
		e[3] = mk_act(1, 1, 3, 31);
		ctrl_ents = '{e};
		send_ctrl_stream(8'h05, ctrl_pkg::CTRL_FLAG, 8'd12);
		send_packet(12, 1, 1'b0);
		wait_idle(200);

		rand_ready = 1'b1;
		for (int i = 0; i < 10; i++)
			send_packet(picks[rand_bits(3) % 5], 1 + int'(rand_bits(2)), rand_bits(3) == 0);
		wait_idle(3000);
		rand_ready = 1'b0;

		check_count("packets", pkt_seen, pkt_exp);
		if (exp_q.size() == 0) begin
			$display("test passed");
			$finish;
		end else begin
			report_failure("expected beats left after the run");
		end
	end

endmodule

/* tb.f */
hdl/deparse_pkg.sv
hdl/ctrl_pkg.sv
hdl/action_table.sv
hdl/field_extractor.sv
hdl/deparse_step_counter.sv
hdl/header_patcher.sv
hdl/deparse_fsm.sv
hdl/egress_stage.sv
hdl/deparser_top.sv
verification/tb_deparser.sv

/* run.sh */
#!/bin/sh
# build and run the deparser testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f tb.f --top-module tb_deparser \
	--Mdir obj_dir -o tb_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "build error"
	exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "test failed" sim.log; then
	exit 1
fi
if [ $sim_status -ne 0 ]; then
	echo "simulator exited with status $sim_status"
	exit 1
fi
exit 0
